/* include/cache_consts.svh */
// Sizing and encodings for the cache directory
// The page splits into one bank-select bit above an 8-bit bank index
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

////////////////////////////////
// Address widths
////////////////////////////////

// Virtual page number width
`define CACHE_PAGE_W 9

// Word offset within a page
`define CACHE_OFFSET_W 9

// Index into one bank, page bits below the bank select
`define CACHE_INDEX_W 8

// Top page bit picks the bank
`define CACHE_BANK_BIT 8

// Entries held by each bank
`define CACHE_BANK_ENTRIES 256

////////////////////////////////
// Microcode special function
////////////////////////////////

`define CACHE_SPEC_W 5

// SPEC/CLRCACHE selects a directory sweep
`define CACHE_SPEC_CLRCACHE 5'h07

`endif

/* rtl/cachePkg.sv */
// Packed types shared by the cache directory RTL and its testbench
// Struct fields are listed MSB first
`include "cache_consts.svh"

package cachePkg;

   ////////////////////////////////
   // Microcode and memory inputs
   ////////////////////////////////

   // Control word, only the fields the cache decodes
   typedef struct packed {
      logic                     memCycle;
      logic                     loadVma;
      logic                     aread;
      logic                     specEn;
      logic [`CACHE_SPEC_W-1:0] specSel;
   } ctrlWord_t;

   // Memory controller status
   typedef struct packed {
      logic acRef;
      logic stopMainMemory;
      logic memoryCycle;
      logic memoryWait;
   } memStatus_t;

   // Pager status for the current reference
   typedef struct packed {
      logic intOrErr;
      logic pageValid;
      logic pageFail5;
      logic pageFail6;
      logic pageEn;
      logic pageCacheable;
      logic cacheEnable;
   } pageStatus_t;

   ////////////////////////////////
   // VMA
   ////////////////////////////////

   // VMA flag bits the cache looks at
   typedef struct packed {
      logic user;
      logic readCycle;
      logic cacheInh;
      logic physical;
   } vmaFlags_t;

   typedef struct packed {
      vmaFlags_t                  flags;
      logic [`CACHE_PAGE_W-1:0]   page;
      logic [`CACHE_OFFSET_W-1:0] offset;
   } vma_t;

   ////////////////////////////////
   // Directory
   ////////////////////////////////

   // One directory entry, tag is the full page number
   typedef struct packed {
      logic                     valid;
      logic                     user;
      logic [`CACHE_PAGE_W-1:0] tag;
   } dirEntry_t;

   // Strobes from decode to the directory
   typedef struct packed {
      logic vmaEn;
      logic cacheWrite;
      logic sweep;
   } cacheStrobes_t;

endpackage

/* rtl/cacheCtrlDecode.sv */
// Pure combinational decode, strobes are levels for the current cycle
// Only the CLRCACHE special function is recognized
`timescale 1ns/100ps
`include "cache_consts.svh"

module cacheCtrlDecode import cachePkg::*;
(
   input  ctrlWord_t     ctrl,
   input  logic          dromVma,
   input  memStatus_t    memStatus,
   output cacheStrobes_t strobes
);

   ////////////////////////////////
   // VMA load
   ////////////////////////////////

   // Microcode asks for the VMA load directly
   logic loadDirect;
   // Dispatch ROM requests the load on an AREAD cycle
   logic loadDispatch;

   assign loadDirect   = ctrl.memCycle & ctrl.loadVma;
   assign loadDispatch = ctrl.memCycle & ctrl.aread & dromVma;

   // Either path loads the VMA and the directory read index
   assign strobes.vmaEn = loadDirect | loadDispatch;

   ////////////////////////////////
   // Sweep
   ////////////////////////////////

   // Special function field matches CLRCACHE
   logic clrCacheSel;

   assign clrCacheSel = (ctrl.specSel == `CACHE_SPEC_CLRCACHE);

   // Field only counts while the special function is enabled
   assign strobes.sweep = ctrl.specEn & clrCacheSel;

   ////////////////////////////////
   // Directory write
   ////////////////////////////////

   // Memory stalled mid cycle, waiting on main memory
   logic memStalled;

   assign memStalled = memStatus.stopMainMemory &
                       memStatus.memoryCycle &
                       memStatus.memoryWait;

   // AC references never go through the cache
   assign strobes.cacheWrite = ~memStatus.acRef & memStalled;

endmodule

/* rtl/cacheDirectory.sv */
// Two banks of 256 entries, selected by the top page bit
// Read is combinational from the registered index, so data lags the load by one edge
`timescale 1ns/100ps
`include "cache_consts.svh"

module cacheDirectory import cachePkg::*;
(
   input  logic          clk,
   input  logic          rst,
   input  logic          clkEn,
   input  cacheStrobes_t strobes,
   input  vma_t          vma,
   output dirEntry_t     entry
);

   localparam int IndexW = `CACHE_INDEX_W;

   // Registered page from the last VMA load
   logic [`CACHE_PAGE_W-1:0] readIdx;

   // Qualified strobes for this edge
   logic loadEn;
   logic writeEn;

   // Write side
   logic              wrBank;
   logic [IndexW-1:0] wrIndex;
   dirEntry_t         wrEntry;

   // Bank storage, no reset
   dirEntry_t bankMem [2][`CACHE_BANK_ENTRIES];

   // Valid bits beside the banks, cleared by reset
   logic [1:0][`CACHE_BANK_ENTRIES-1:0] validBits;

   // Read side
   logic              rdBank;
   logic [IndexW-1:0] rdIndex;
   dirEntry_t         rdEntry;
   logic              rdValid;

   ////////////////////////////////
   // Strobe qualification
   ////////////////////////////////

   assign loadEn  = clkEn & strobes.vmaEn;
   // Writes only ride along with a VMA load
   assign writeEn = loadEn & strobes.cacheWrite;

   assign wrBank  = vma.page[`CACHE_BANK_BIT];
   assign wrIndex = vma.page[IndexW-1:0];

   // Sweep writes an all-zero entry, otherwise tag the current page
   always_comb
   begin
      if (strobes.sweep)
         wrEntry = '0;
      else
         wrEntry = '{valid: 1'b1, user: vma.flags.user, tag: vma.page};
   end

   ////////////////////////////////
   // Read index
   ////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         readIdx <= '0;
      else if (loadEn)
         readIdx <= vma.page;
   end

   ////////////////////////////////
   // Valid array
   ////////////////////////////////

   // Normal write sets one bank, sweep clears the index in both
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         validBits <= '0;
      else if (writeEn)
      begin
         for (int b = 0; b < 2; b++)
         begin
            if (strobes.sweep || (b == int'(wrBank)))
               validBits[b][wrIndex] <= ~strobes.sweep;
         end
      end
   end

   ////////////////////////////////
   // Bank storage
   ////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (writeEn)
      begin
         for (int b = 0; b < 2; b++)
         begin
            if (strobes.sweep || (b == int'(wrBank)))
               bankMem[b][wrIndex] <= wrEntry;
         end
      end
   end

   ////////////////////////////////
   // Read
   ////////////////////////////////

   assign rdBank  = readIdx[`CACHE_BANK_BIT];
   assign rdIndex = readIdx[IndexW-1:0];
   assign rdEntry = bankMem[rdBank][rdIndex];

   // Stored valid only counts once the reset-cleared bit agrees
   assign rdValid = validBits[rdBank][rdIndex] & rdEntry.valid;

   // Invalid slots read as all zero, same as a swept entry
   assign entry = rdValid ? rdEntry : '0;

   ////////////////////////////////
   // Checks
   ////////////////////////////////

   // Written page becomes the read index, so it must show valid next cycle
   property pWriteVisible;
      @(posedge clk) disable iff (rst)
         (writeEn && !strobes.sweep) |=> entry.valid;
   endproperty

   writeVisibleChk: assert property (pWriteVisible)
      else $error("cacheDirectory: entry invalid after write, page=%h", $past(vma.page));

endmodule

/* rtl/cacheHitDetect.sv */
// Combinational hit qualification against the entry of the current cycle
// vmaJustLoaded only suppresses cacheHit, never cacheHitEn
`timescale 1ns/100ps
`include "cache_consts.svh"

module cacheHitDetect import cachePkg::*;
(
   input  dirEntry_t                entry,
   input  vma_t                     vma,
   input  pageStatus_t              pageStatus,
   input  logic                     vmaJustLoaded,
   output logic                     cacheValid,
   output logic                     cacheUser,
   output logic [`CACHE_PAGE_W-1:0] cacheAddr,
   output logic                     cacheHitEn,
   output logic                     cacheHit
);

   // Pager allows a cached access
   logic pageOk;
   // VMA flags allow a cached access
   logic vmaOk;
   // Entry belongs to this page and mode
   logic entryMatch;

   ////////////////////////////////
   // Entry fields
   ////////////////////////////////

   assign cacheValid = entry.valid;
   assign cacheUser  = entry.user;
   assign cacheAddr  = entry.tag;

   ////////////////////////////////
   // Qualifiers
   ////////////////////////////////

   // No page failure, page mapped and cacheable, cache turned on
   assign pageOk = pageStatus.intOrErr &
                   pageStatus.pageValid &
                   ~pageStatus.pageFail5 &
                   ~pageStatus.pageFail6 &
                   pageStatus.pageEn &
                   pageStatus.pageCacheable &
                   pageStatus.cacheEnable;

   // Virtual read, cache not inhibited
   assign vmaOk = vma.flags.readCycle &
                  ~vma.flags.cacheInh &
                  ~vma.flags.physical;

   // Tag holds the whole page, both banks compare all bits
   assign entryMatch = entry.valid &
                       (entry.user == vma.flags.user) &
                       (entry.tag == vma.page);

   ////////////////////////////////
   // Hit
   ////////////////////////////////

   assign cacheHitEn = pageOk & vmaOk & entryMatch;

   // Entry still reflects the previous VMA right after a load
   assign cacheHit = cacheHitEn & ~vmaJustLoaded;

endmodule

/* rtl/cacheSubsys.sv */
// Cache directory subsystem, decode into directory into hit detect
// All state sits in the directory, hit outputs follow the VMA combinationally
`timescale 1ns/100ps
`include "cache_consts.svh"

module cacheSubsys import cachePkg::*;
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     clkEn,
   input  ctrlWord_t                ctrl,
   input  logic                     dromVma,
   input  vma_t                     vma,
   input  memStatus_t               memStatus,
   input  pageStatus_t              pageStatus,
   input  logic                     vmaJustLoaded,
   output logic                     cacheValid,
   output logic                     cacheUser,
   output logic [`CACHE_PAGE_W-1:0] cacheAddr,
   output logic                     cacheHitEn,
   output logic                     cacheHit
);

   // Load, write and sweep strobes
   cacheStrobes_t strobes;
   // Entry at the registered read index
   dirEntry_t     entry;

   ////////////////////////////////
   // Decode
   ////////////////////////////////

   cacheCtrlDecode ctrlDecode
   (
      .ctrl      (ctrl),
      .dromVma   (dromVma),
      .memStatus (memStatus),
      .strobes   (strobes)
   );

   ////////////////////////////////
   // Directory
   ////////////////////////////////

   cacheDirectory directory
   (
      .clk     (clk),
      .rst     (rst),
      .clkEn   (clkEn),
      .strobes (strobes),
      .vma     (vma),
      .entry   (entry)
   );

   ////////////////////////////////
   // Hit detect
   ////////////////////////////////

   cacheHitDetect hitDetect
   (
      .entry         (entry),
      .vma           (vma),
      .pageStatus    (pageStatus),
      .vmaJustLoaded (vmaJustLoaded),
      .cacheValid    (cacheValid),
      .cacheUser     (cacheUser),
      .cacheAddr     (cacheAddr),
      .cacheHitEn    (cacheHitEn),
      .cacheHit      (cacheHit)
   );

endmodule

/* verification/cacheSubsysTb.sv */
// Testbench for the cache directory subsystem, one VMA load per table row
// Expected values come from a page-indexed reference directory
`timescale 1ns/100ps
`include "cache_consts.svh"

module cacheSubsysTb import cachePkg::*;
();

   localparam int PageW        = `CACHE_PAGE_W;
   localparam int IndexW       = `CACHE_INDEX_W;
   localparam int ResetTimeout = 10;
   localparam int FillCount    = 24;

   // Row operations
   localparam logic [2:0] OpLookup  = 3'd0;
   localparam logic [2:0] OpWrite   = 3'd1;
   localparam logic [2:0] OpSweep   = 3'd2;
   localparam logic [2:0] OpNoVma   = 3'd3;
   localparam logic [2:0] OpNoClkEn = 3'd4;
   localparam logic [2:0] OpAcRef   = 3'd5;

   // All pager qualifiers true
   localparam pageStatus_t PsGood = 7'b1100111;
   // Flags {readCycle, cacheInh, physical} for a cached virtual read
   localparam logic [2:0] FlGood = 3'b100;

   typedef struct packed {
      logic [2:0]       op;
      logic [PageW-1:0] page;
      logic             user;
      logic [2:0]       flags;
      pageStatus_t      ps;
      logic             justLoaded;
   } row_t;

   logic             clk;
   logic             rst;
   logic             clkEn;
   ctrlWord_t        ctrl;
   logic             dromVma;
   vma_t             vma;
   memStatus_t       memStatus;
   pageStatus_t      pageStatus;
   logic             vmaJustLoaded;
   logic             cacheValid;
   logic             cacheUser;
   logic [PageW-1:0] cacheAddr;
   logic             cacheHitEn;
   logic             cacheHit;

   row_t             rowQ[$];
   // Reference directory, indexed by the full page so both banks are covered
   dirEntry_t        refDir [2*`CACHE_BANK_ENTRIES];
   logic [PageW-1:0] refIdx;
   int               errorCount;
   int               failedRows;
   bit               resetOk;

   cacheSubsys uut (.*);

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // No load, no write, clock enabled
   task automatic driveIdle();
      ctrl      = '0;
      dromVma   = 1'b0;
      memStatus = '0;
      clkEn     = 1'b1;
   endtask

   function automatic void addRow(logic [2:0] op, logic [PageW-1:0] page, logic user,
                                  logic [2:0] flags, pageStatus_t ps, logic justLoaded);
      rowQ.push_back('{op, page, user, flags, ps, justLoaded});
   endfunction

   ////////////////////////////////
   // Stimulus table
   ////////////////////////////////

   task automatic buildTable();
      logic [PageW-1:0] fillPage [FillCount];
      logic             fillUser [FillCount];
      // Empty directory after reset
      addRow(OpLookup, 9'h000, 1'b0, FlGood, PsGood, 1'b0);
      addRow(OpLookup, 9'h1ff, 1'b1, FlGood, PsGood, 1'b0);
      addRow(OpLookup, 9'h055, 1'b0, FlGood, PsGood, 1'b0);
      // Write then hit, then user mismatch
      addRow(OpWrite, 9'h023, 1'b1, FlGood, PsGood, 1'b0);
      addRow(OpLookup, 9'h023, 1'b1, FlGood, PsGood, 1'b0);
      addRow(OpLookup, 9'h023, 1'b0, FlGood, PsGood, 1'b0);
      // Bank split on the top page bit
      addRow(OpWrite, 9'h1a5, 1'b0, FlGood, PsGood, 1'b0);
      addRow(OpWrite, 9'h0a5, 1'b1, FlGood, PsGood, 1'b0);
      addRow(OpLookup, 9'h1a5, 1'b0, FlGood, PsGood, 1'b0);
      addRow(OpLookup, 9'h0a5, 1'b1, FlGood, PsGood, 1'b0);
      // Sweep clears the index in both banks
      addRow(OpSweep, 9'h0a5, 1'b1, FlGood, PsGood, 1'b0);
      addRow(OpLookup, 9'h0a5, 1'b1, FlGood, PsGood, 1'b0);
      addRow(OpLookup, 9'h1a5, 1'b0, FlGood, PsGood, 1'b0);
      // One qualifier off per row
      addRow(OpWrite, 9'h077, 1'b0, FlGood, PsGood, 1'b0);
      addRow(OpLookup, 9'h077, 1'b0, 3'b110, PsGood, 1'b0);
      addRow(OpLookup, 9'h077, 1'b0, 3'b101, PsGood, 1'b0);
      addRow(OpLookup, 9'h077, 1'b0, 3'b000, PsGood, 1'b0);
      addRow(OpLookup, 9'h077, 1'b0, FlGood, 7'b1110111, 1'b0);
      addRow(OpLookup, 9'h077, 1'b0, FlGood, 7'b1101111, 1'b0);
      addRow(OpLookup, 9'h077, 1'b0, FlGood, 7'b1100101, 1'b0);
      addRow(OpLookup, 9'h077, 1'b0, FlGood, 7'b1100110, 1'b0);
      addRow(OpLookup, 9'h077, 1'b0, FlGood, 7'b0100111, 1'b0);
      addRow(OpLookup, 9'h077, 1'b0, FlGood, PsGood, 1'b1);
      // Blocked writes
      addRow(OpNoVma, 9'h0c3, 1'b1, FlGood, PsGood, 1'b0);
      addRow(OpLookup, 9'h0c3, 1'b1, FlGood, PsGood, 1'b0);
      addRow(OpNoClkEn, 9'h0c3, 1'b1, FlGood, PsGood, 1'b0);
      addRow(OpLookup, 9'h0c3, 1'b1, FlGood, PsGood, 1'b0);
      addRow(OpAcRef, 9'h0c3, 1'b1, FlGood, PsGood, 1'b0);
      addRow(OpLookup, 9'h0c3, 1'b1, FlGood, PsGood, 1'b0);
      // Random fill, then read back in order
      for (int i = 0; i < FillCount; i++)
      begin
         fillPage[i] = PageW'($urandom);
         fillUser[i] = 1'($urandom);
         addRow(OpWrite, fillPage[i], fillUser[i], FlGood, PsGood, 1'b0);
      end
      for (int i = 0; i < FillCount; i++)
         addRow(OpLookup, fillPage[i], fillUser[i], FlGood, PsGood, 1'b0);
   endtask

   ////////////////////////////////
   // Checking
   ////////////////////////////////

   task automatic checkVal(input string name, input int rowNum, input logic [PageW-1:0] got,
                           input logic [PageW-1:0] exp, inout int errs);
      assert (got === exp)
      else
      begin
         $display("FAILED row %0d %s got %h expected %h", rowNum, name, got, exp);
         errs++;
      end
   endtask

   // Load edge with the row's strobes, then compare against the model
   task automatic applyRow(input row_t r, input int rowNum);
      int        errs;
      logic      doLoad;
      logic      doWrite;
      logic      hitEnExp;
      dirEntry_t e;
      errs = 0;
      @(posedge clk);
      #1;
      vma.flags     = {r.user, r.flags};
      vma.page      = r.page;
      pageStatus    = r.ps;
      vmaJustLoaded = r.justLoaded;
      clkEn         = (r.op != OpNoClkEn);
      // Lookups load through the dispatch path, the rest through loadVma
      ctrl.memCycle = 1'b1;
      ctrl.loadVma  = (r.op != OpNoVma) && (r.op != OpLookup);
      ctrl.aread    = 1'b1;
      dromVma       = (r.op == OpLookup);
      ctrl.specEn   = (r.op == OpSweep);
      ctrl.specSel  = `CACHE_SPEC_CLRCACHE;
      memStatus     = {r.op == OpAcRef, r.op != OpLookup, 1'b1, 1'b1};
      @(posedge clk);
      doLoad  = (r.op != OpNoVma) && (r.op != OpNoClkEn);
      doWrite = doLoad && (r.op == OpWrite || r.op == OpSweep);
      if (doLoad)
         refIdx = r.page;
      if (doWrite && r.op == OpSweep)
      begin
         refDir[{1'b0, r.page[IndexW-1:0]}] = '0;
         refDir[{1'b1, r.page[IndexW-1:0]}] = '0;
      end
      else if (doWrite)
         refDir[r.page] = '{valid: 1'b1, user: r.user, tag: r.page};
      #1;
      driveIdle();
      #10;
      e        = refDir[refIdx];
      hitEnExp = r.ps.intOrErr & r.ps.pageValid & ~r.ps.pageFail5 & ~r.ps.pageFail6 &
                 r.ps.pageEn & r.ps.pageCacheable & r.ps.cacheEnable &
                 r.flags[2] & ~r.flags[1] & ~r.flags[0] &
                 e.valid & (e.user == r.user) & (e.tag == r.page);
      checkVal("cacheValid", rowNum, cacheValid, e.valid, errs);
      checkVal("cacheUser", rowNum, cacheUser, e.user, errs);
      checkVal("cacheAddr", rowNum, cacheAddr, e.tag, errs);
      checkVal("cacheHitEn", rowNum, cacheHitEn, hitEnExp, errs);
      checkVal("cacheHit", rowNum, cacheHit, hitEnExp & ~r.justLoaded, errs);
      if (errs != 0)
         failedRows++;
      errorCount += errs;
      $display("Row %0d op %0d page %h: %s", rowNum, r.op, r.page,
               (errs == 0) ? "ok" : "mismatch");
   endtask

   // Outputs must settle low once reset is released
   task automatic waitOutputsLow(output bit ok);
      int n;
      n = 0;
      while ((cacheValid !== 1'b0 || cacheUser !== 1'b0 || cacheHitEn !== 1'b0 ||
              cacheHit !== 1'b0 || cacheAddr !== '0) && n < ResetTimeout)
      begin
         @(posedge clk);
         n++;
      end
      ok = (n < ResetTimeout);
   endtask

   ////////////////////////////////
   // Main sequence
   ////////////////////////////////

   initial
   begin
      void'($urandom(32'h40d8ece6));
      errorCount    = 0;
      failedRows    = 0;
      refIdx        = '0;
      rst           = 1'b1;
      vma           = '0;
      pageStatus    = PsGood;
      vmaJustLoaded = 1'b0;
      driveIdle();
      foreach (refDir[i])
         refDir[i] = '0;
      buildTable();
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;
      waitOutputsLow(resetOk);
      if (!resetOk)
      begin
         $display("Timeout: outputs stayed nonzero after reset release");
         $display("Test failed");
         $finish;
      end
      else
      begin
         foreach (rowQ[i])
            applyRow(rowQ[i], i);
         $display("Summary: %0d rows, %0d failed rows, %0d check errors",
                  rowQ.size(), failedRows, errorCount);
         if (failedRows == 0)
            $display("Test passed");
         else
            $display("Test failed");
         $finish;
      end
   end

endmodule

/* sources.f */
+incdir+include
rtl/cachePkg.sv
rtl/cacheCtrlDecode.sv
rtl/cacheDirectory.sv
rtl/cacheHitDetect.sv
rtl/cacheSubsys.sv
verification/cacheSubsysTb.sv
